/* soc_pb_defines.svh */
/*
 * peripheral bus parameters
 * address width, peripheral select bit and write-mask codes
 */

`ifndef SOC_PB_DEFINES_SVH
`define SOC_PB_DEFINES_SVH

// bus address width in bits
`define PB_AW 8

// address bit that picks the peripheral
// set selects the GPIO block, clear selects the SPI master
`define PB_SEL_BIT 4

// write-mask codes
// SPI control write, carries cs_en in bit 8
`define WE_SPI_CR 4'b0011
// SPI data write, one bit per command
`define WE_SPI_DR 4'b0001
// GPIO output register write
`define WE_GPIO_OUT 4'b1111

`endif

/* pb_pkg.sv */
/*
 * peripheral bus types
 * address, write mask, data word and slave index
 */

`default_nettype none

`include "soc_pb_defines.svh"

package pb_pkg;

   // bus address
   typedef logic [`PB_AW-1:0] pb_addr_t;

   // write mask, one bit per byte lane
   typedef logic [3:0] pb_we_t;

   // one bus data word
   typedef logic [31:0] pb_data_t;

   // which peripheral owns a command or a response
   // encoding follows the address select bit
   typedef enum logic {
      SLV_SPI  = 1'b0,
      SLV_GPIO = 1'b1
   } pb_slave_e;

endpackage

`default_nettype wire

/* spi_pkg.sv */
/*
 * SPI master register views
 * one bus data word read as control or as data
 */

`default_nettype none

package spi_pkg;

   // control view, chip select enable in bit 8
   typedef struct packed {
      logic [22:0] rsvd_hi;
      logic        cs_en;
      logic [7:0]  rsvd_lo;
   } spi_cr_t;

   // data view, only tx_byte bit 7 goes out on MOSI
   typedef struct packed {
      logic [23:0] rsvd;
      logic [7:0]  tx_byte;
   } spi_dr_t;

   // same 32-bit word, decoded by the write mask
   typedef union packed {
      spi_cr_t cr;
      spi_dr_t dr;
   } spi_word_u;

endpackage

`default_nettype wire

/* pb_if.sv */
/*
 * per-peripheral bus bundle
 * command and response signals with master and slave modports
 */

`default_nettype none

interface pb_if;
   import pb_pkg::*;

   // command channel
   logic     cmd_valid;
   logic     cmd_ready;
   pb_addr_t addr;
   pb_we_t   we_msk;
   pb_data_t din;

   // response channel
   pb_data_t dout;
   logic     rsp_valid;
   logic     rsp_ready;

   // decoder and response combiner side
   modport master (
      output cmd_valid, addr, we_msk, din, rsp_ready,
      input  cmd_ready, dout, rsp_valid
   );

   // peripheral side
   modport slave (
      input  cmd_valid, addr, we_msk, din, rsp_ready,
      output cmd_ready, dout, rsp_valid
   );

endinterface

`default_nettype wire

/* pb_addr_decode.sv */
/*
 * command decoder
 * routes one bus command to the SPI master or the GPIO block
 * and stalls new commands while a response is pending
 */

`default_nettype none

`include "soc_pb_defines.svh"

module pb_addr_decode (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             cmd_valid,
   output logic             cmd_ready,
   input  pb_pkg::pb_addr_t addr,
   input  pb_pkg::pb_we_t   we_msk,
   input  pb_pkg::pb_data_t din,
   input  logic             rsp_pending,
   pb_if.master             spi_bus,
   pb_if.master             gpio_bus
);
   import pb_pkg::*;

   pb_slave_e sel;
   logic      fwd_ok;

   // peripheral picked straight from the address
   assign sel = pb_slave_e'(addr[`PB_SEL_BIT]);

   // only one command outstanding
   assign fwd_ok = cmd_valid & ~rsp_pending;

   // valid goes to the addressed peripheral only
   assign spi_bus.cmd_valid  = fwd_ok & (sel == SLV_SPI);
   assign gpio_bus.cmd_valid = fwd_ok & (sel == SLV_GPIO);

   // payload fans out to both, harmless without valid
   assign spi_bus.addr    = addr;
   assign spi_bus.we_msk  = we_msk;
   assign spi_bus.din     = din;
   assign gpio_bus.addr   = addr;
   assign gpio_bus.we_msk = we_msk;
   assign gpio_bus.din    = din;

   // ready of the addressed peripheral, held off by a pending response
   always_comb begin
      if (sel == SLV_GPIO) begin
         cmd_ready = gpio_bus.cmd_ready & ~rsp_pending;
      end else begin
         cmd_ready = spi_bus.cmd_ready & ~rsp_pending;
      end
   end

   // a command never reaches both peripherals
   a_one_target : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(spi_bus.cmd_valid && gpio_bus.cmd_valid)
   ) else $error("command forwarded to both peripherals");

endmodule

`default_nettype wire

/* soc_pb_spi_master.sv */
/*
 * bit-level SPI master
 * chip select, one-cycle SCK pulse, registered MOSI, MISO shift register
 */

`default_nettype none

`include "soc_pb_defines.svh"

module soc_pb_spi_master (
   input  logic clk,
   input  logic rst_n,
   pb_if.slave  bus,
   output logic spi_sck,
   output logic spi_cs_l,
   output logic spi_mosi,
   input  logic spi_miso
);
   import spi_pkg::*;

   spi_word_u  cmd_w;
   logic       hds_cmd;
   logic       hds_rsp;
   logic       we_cr;
   logic       we_dr;
   logic [7:0] rx_sh;

   // handshakes on both channels
   assign hds_cmd = bus.cmd_valid & bus.cmd_ready;
   assign hds_rsp = bus.rsp_valid & bus.rsp_ready;

   // write mask picks the view of din
   assign cmd_w = bus.din;
   assign we_cr = (bus.we_msk == `WE_SPI_CR);
   assign we_dr = (bus.we_msk == `WE_SPI_DR);

   // one SCK pulse per data write, high the cycle after the handshake
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         spi_sck <= 1'b0;
      end else begin
         spi_sck <= hds_cmd & we_dr;
      end
   end

   // chip select, MOSI and receive shift register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         spi_cs_l <= 1'b1;
         spi_mosi <= 1'b0;
         rx_sh    <= 8'h00;
      end else if (hds_cmd) begin
         if (we_cr) begin
            // active-low select output
            spi_cs_l <= ~cmd_w.cr.cs_en;
         end
         if (we_dr) begin
            // MOSI set together with SCK so it holds over the pulse
            spi_mosi <= cmd_w.dr.tx_byte[7];
            // MISO sampled on the handshake edge, enters at bit 0
            rx_sh    <= {rx_sh[6:0], spi_miso};
         end
      end
   end

   // response flag, set on command, cleared when taken
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bus.rsp_valid <= 1'b0;
      end else if (hds_cmd) begin
         bus.rsp_valid <= 1'b1;
      end else if (hds_rsp) begin
         bus.rsp_valid <= 1'b0;
      end
   end

   // no new command while a response waits
   assign bus.cmd_ready = ~bus.rsp_valid;

   // rx_sh only moves on a handshake, so dout is stable under back-pressure
   assign bus.dout = {24'h000000, rx_sh};

   // SCK is a single-cycle pulse
   a_sck_pulse : assert property (
      @(posedge clk) disable iff (!rst_n)
      spi_sck |=> !spi_sck
   ) else $error("SCK high for two cycles");

endmodule

`default_nettype wire

/* soc_pb_gpio.sv */
/*
 * GPIO peripheral
 * output register and two-flop input synchronizer
 */

`default_nettype none

`include "soc_pb_defines.svh"

module soc_pb_gpio (
   input  logic       clk,
   input  logic       rst_n,
   pb_if.slave        bus,
   output logic [7:0] gpio_out,
   input  logic [7:0] gpio_in
);

   logic        hds_cmd;
   logic        hds_rsp;
   logic [7:0]  gpio_out_nxt;
   logic [7:0]  in_meta;
   logic [7:0]  in_sync;
   logic [15:0] rd_q;

   assign hds_cmd = bus.cmd_valid & bus.cmd_ready;
   assign hds_rsp = bus.rsp_valid & bus.rsp_ready;

   // only the full-word mask writes the output register
   always_comb begin
      gpio_out_nxt = gpio_out;
      if (hds_cmd && (bus.we_msk == `WE_GPIO_OUT)) begin
         gpio_out_nxt = bus.din[7:0];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gpio_out <= 8'h00;
      end else begin
         gpio_out <= gpio_out_nxt;
      end
   end

   // input synchronizer
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_meta <= 8'h00;
         in_sync <= 8'h00;
      end else begin
         in_meta <= gpio_in;
         in_sync <= in_meta;
      end
   end

   // read data captured with the command, held until taken
   always_ff @(posedge clk) begin
      if (hds_cmd) begin
         rd_q <= {in_sync, gpio_out_nxt};
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bus.rsp_valid <= 1'b0;
      end else if (hds_cmd) begin
         bus.rsp_valid <= 1'b1;
      end else if (hds_rsp) begin
         bus.rsp_valid <= 1'b0;
      end
   end

   assign bus.cmd_ready = ~bus.rsp_valid;
   assign bus.dout      = {16'h0000, rd_q};

   // decoder only hands over GPIO-addressed commands
   a_gpio_addr : assert property (
      @(posedge clk) disable iff (!rst_n)
      hds_cmd |-> bus.addr[`PB_SEL_BIT]
   ) else $error("GPIO took a command addressed to the SPI master");

endmodule

`default_nettype wire

/* pb_resp_mux.sv */
/*
 * response combiner
 * merges the two peripheral responses onto the bus, routes ready back
 */

`default_nettype none

module pb_resp_mux (
   input  logic             clk,
   input  logic             rst_n,
   pb_if.master             spi_bus,
   pb_if.master             gpio_bus,
   output logic             rsp_valid,
   output pb_pkg::pb_data_t dout,
   input  logic             rsp_ready,
   output logic             rsp_pending
);
   import pb_pkg::*;

   pb_slave_e owner;
   pb_slave_e owner_q;

   // owner follows whoever is valid, else keeps the last one
   always_comb begin
      if (gpio_bus.rsp_valid) begin
         owner = SLV_GPIO;
      end else if (spi_bus.rsp_valid) begin
         owner = SLV_SPI;
      end else begin
         owner = owner_q;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         owner_q <= SLV_SPI;
      end else begin
         owner_q <= owner;
      end
   end

   assign rsp_valid   = spi_bus.rsp_valid | gpio_bus.rsp_valid;
   // same condition, fed to the decoder as the stall
   assign rsp_pending = spi_bus.rsp_valid | gpio_bus.rsp_valid;

   assign dout = (owner == SLV_GPIO) ? gpio_bus.dout : spi_bus.dout;

   // ready goes only to the owner
   assign spi_bus.rsp_ready  = rsp_ready & (owner == SLV_SPI);
   assign gpio_bus.rsp_ready = rsp_ready & (owner == SLV_GPIO);

   // one command outstanding means one response at a time
   a_one_rsp : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(spi_bus.rsp_valid && gpio_bus.rsp_valid)
   ) else $error("both peripherals hold a response");

endmodule

`default_nettype wire

/* soc_pb_periph_top.sv */
/*
 * peripheral bus subsystem top level
 * decoder, SPI master, GPIO block and response combiner
 */

`default_nettype none

`include "soc_pb_defines.svh"

module soc_pb_periph_top (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             cmd_valid,
   output logic             cmd_ready,
   input  logic [`PB_AW-1:0] addr,
   input  logic [3:0]       we_msk,
   input  logic [31:0]      din,
   output logic [31:0]      dout,
   output logic             rsp_valid,
   input  logic             rsp_ready,
   output logic             spi_sck,
   output logic             spi_cs_l,
   output logic             spi_mosi,
   input  logic             spi_miso,
   output logic [7:0]       gpio_out,
   input  logic [7:0]       gpio_in
);

   logic rsp_pending;

   // one bundle per peripheral
   pb_if spi_bus ();
   pb_if gpio_bus ();

   pb_addr_decode u_decode (
      .clk         (clk),
      .rst_n       (rst_n),
      .cmd_valid   (cmd_valid),
      .cmd_ready   (cmd_ready),
      .addr        (addr),
      .we_msk      (we_msk),
      .din         (din),
      .rsp_pending (rsp_pending),
      .spi_bus     (spi_bus.master),
      .gpio_bus    (gpio_bus.master)
   );

   soc_pb_spi_master u_spi (
      .clk      (clk),
      .rst_n    (rst_n),
      .bus      (spi_bus.slave),
      .spi_sck  (spi_sck),
      .spi_cs_l (spi_cs_l),
      .spi_mosi (spi_mosi),
      .spi_miso (spi_miso)
   );

   soc_pb_gpio u_gpio (
      .clk      (clk),
      .rst_n    (rst_n),
      .bus      (gpio_bus.slave),
      .gpio_out (gpio_out),
      .gpio_in  (gpio_in)
   );

   // response side watches both bundles
   pb_resp_mux u_resp (
      .clk         (clk),
      .rst_n       (rst_n),
      .spi_bus     (spi_bus.master),
      .gpio_bus    (gpio_bus.master),
      .rsp_valid   (rsp_valid),
      .dout        (dout),
      .rsp_ready   (rsp_ready),
      .rsp_pending (rsp_pending)
   );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
/*
 * testbench clock and reset source
 * 4 ns clock, active-low reset held for 3 cycles
 */

`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS  = 4,
   parameter int RST_CYCLES = 3
) (
   output logic clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // release just after an edge so the first active edge is clean
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

/* tb_soc_pb_periph.sv */
/*
 * testbench for the peripheral bus subsystem
 * random commands from a fixed seed, reference model of the SPI master
 * and the GPIO block, compare tasks and a watchdog
 */

`default_nettype none

`include "soc_pb_defines.svh"

module tb_soc_pb_periph;
   timeunit 1ns;
   timeprecision 100ps;
   import pb_pkg::*;

   localparam int CLK_NS = 4;
   // commands over all tests, sizes the watchdog
   localparam int N_CMDS = 112;

   logic       clk;
   logic       rst_n;
   logic       cmd_valid;
   logic       cmd_ready;
   pb_addr_t   addr;
   pb_we_t     we_msk;
   pb_data_t   din;
   pb_data_t   dout;
   logic       rsp_valid;
   logic       rsp_ready;
   logic       spi_sck;
   logic       spi_cs_l;
   logic       spi_mosi;
   logic       spi_miso;
   logic [7:0] gpio_out;
   logic [7:0] gpio_in;

   // reference model state
   logic       m_cs;
   logic [7:0] m_rx;
   logic [7:0] m_gpio;

   integer seed = 86;
   int     err_cnt = 0;
   int     test_err0 = 0;
   int     pass_cnt = 0;
   int     fail_cnt = 0;
   // longest random stretch of rsp_ready low
   int     bp_max = 0;
   string  test_name;

   tb_clk_gen u_clk (
      .clk   (clk),
      .rst_n (rst_n)
   );

   soc_pb_periph_top UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .addr      (addr),
      .we_msk    (we_msk),
      .din       (din),
      .dout      (dout),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .spi_sck   (spi_sck),
      .spi_cs_l  (spi_cs_l),
      .spi_mosi  (spi_mosi),
      .spi_miso  (spi_miso),
      .gpio_out  (gpio_out),
      .gpio_in   (gpio_in)
   );

   task automatic chk_data(input string what, input pb_data_t exp, input pb_data_t act);
      if (act !== exp) begin
         $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
         err_cnt++;
      end
   endtask

   task automatic chk_bit(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
         err_cnt++;
      end
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_err0 = err_cnt;
   endtask

   task automatic finish_test();
      if (err_cnt == test_err0) begin
         pass_cnt++;
         $display("test %s: ok", test_name);
      end else begin
         fail_cnt++;
         $display("test %s: %0d error(s)", test_name, err_cnt - test_err0);
      end
   endtask

   // random address, select bit forced to the wanted peripheral
   function automatic pb_addr_t pick_addr(input logic to_gpio);
      logic [31:0] r;
      pb_addr_t    a;
      r = $random(seed);
      a = r[`PB_AW-1:0];
      a[`PB_SEL_BIT] = to_gpio;
      return a;
   endfunction

   // mostly real codes, sometimes a mask that does nothing
   function automatic pb_we_t pick_msk();
      logic [31:0] r;
      r = $random(seed);
      case (r[5:4])
         2'd0: return `WE_SPI_CR;
         2'd1: return `WE_SPI_DR;
         2'd2: return `WE_GPIO_OUT;
         default: return r[3:0];
      endcase
   endfunction

   // new pin value, held long enough to pass the synchronizer
   task automatic set_gpio_in();
      logic [31:0] r;
      r = $random(seed);
      gpio_in = r[7:0];
      repeat (3) @(posedge clk);
      #1;
   endtask

   // one command and its response, checked against the model
   task automatic bus_cmd(input pb_addr_t a, input pb_we_t msk, input pb_data_t d);
      logic        to_gpio;
      logic        miso;
      logic [31:0] r;
      pb_data_t    exp;
      int          stalls;
      to_gpio = a[`PB_SEL_BIT];
      r = $random(seed);
      miso = r[0];
      stalls = (bp_max > 0) ? ({$random(seed)} % (bp_max + 1)) : 0;
      // model update, response shows the state after the write
      if (to_gpio) begin
         if (msk == `WE_GPIO_OUT) begin
            m_gpio = d[7:0];
         end
         exp = {16'h0000, gpio_in, m_gpio};
      end else begin
         if (msk == `WE_SPI_CR) begin
            m_cs = d[8];
         end
         if (msk == `WE_SPI_DR) begin
            m_rx = {m_rx[6:0], miso};
         end
         exp = {24'h000000, m_rx};
      end
      cmd_valid = 1'b1;
      addr = a;
      we_msk = msk;
      din = d;
      spi_miso = miso;
      while (!cmd_ready) begin
         @(posedge clk);
         #1;
      end
      chk_bit("rsp_valid before take", 1'b0, rsp_valid);
      // handshake edge
      @(posedge clk);
      #1;
      cmd_valid = 1'b0;
      chk_bit("rsp_valid", 1'b1, rsp_valid);
      chk_bit("cmd_ready busy", 1'b0, cmd_ready);
      chk_data("dout", exp, dout);
      chk_bit("spi_cs_l", ~m_cs, spi_cs_l);
      chk_data("gpio_out", {24'h000000, m_gpio}, {24'h000000, gpio_out});
      if (!to_gpio && (msk == `WE_SPI_DR)) begin
         chk_bit("spi_sck pulse", 1'b1, spi_sck);
         chk_bit("spi_mosi", d[7], spi_mosi);
      end else begin
         chk_bit("spi_sck idle", 1'b0, spi_sck);
      end
      // back-pressure, response must hold still
      rsp_ready = (stalls == 0);
      while (stalls > 0) begin
         @(posedge clk);
         #1;
         stalls--;
         chk_bit("spi_sck fall", 1'b0, spi_sck);
         chk_bit("rsp_valid held", 1'b1, rsp_valid);
         chk_data("dout held", exp, dout);
         chk_bit("cmd_ready stalled", 1'b0, cmd_ready);
         rsp_ready = (stalls == 0);
      end
      // response taken on this edge
      @(posedge clk);
      #1;
      rsp_ready = 1'b0;
      chk_bit("rsp_valid drop", 1'b0, rsp_valid);
      chk_bit("cmd_ready back", 1'b1, cmd_ready);
      chk_bit("spi_sck low", 1'b0, spi_sck);
   endtask

   initial begin
      logic [31:0] r;
      cmd_valid = 1'b0;
      addr = '0;
      we_msk = '0;
      din = '0;
      rsp_ready = 1'b0;
      spi_miso = 1'b0;
      gpio_in = 8'h00;
      m_cs = 1'b0;
      m_rx = 8'h00;
      m_gpio = 8'h00;
      @(posedge rst_n);
      @(posedge clk);
      #1;

      begin_test("reset");
      chk_bit("cmd_ready", 1'b1, cmd_ready);
      chk_bit("rsp_valid", 1'b0, rsp_valid);
      chk_bit("spi_sck", 1'b0, spi_sck);
      chk_bit("spi_cs_l", 1'b1, spi_cs_l);
      chk_data("gpio_out", 32'h0, {24'h000000, gpio_out});
      finish_test();

      // cs_en lands on a random bit 8
      begin_test("spi control");
      for (int i = 0; i < 16; i++) begin
         r = $random(seed);
         bus_cmd(pick_addr(1'b0), `WE_SPI_CR, r);
      end
      finish_test();

      // eight bits shift a full byte through the receive register
      begin_test("spi data");
      for (int i = 0; i < 8; i++) begin
         r = $random(seed);
         bus_cmd(pick_addr(1'b0), `WE_SPI_DR, r);
      end
      finish_test();

      begin_test("gpio");
      for (int i = 0; i < 4; i++) begin
         set_gpio_in();
         r = $random(seed);
         bus_cmd(pick_addr(1'b1), `WE_GPIO_OUT, r);
         r = $random(seed);
         bus_cmd(pick_addr(1'b1), 4'b0000, r);
      end
      finish_test();

      begin_test("back-pressure");
      bp_max = 7;
      for (int i = 0; i < 16; i++) begin
         r = $random(seed);
         bus_cmd(pick_addr(r[9]), pick_msk(), r);
      end
      finish_test();

      // both peripherals, any mask, short stalls
      begin_test("random mix");
      bp_max = 2;
      for (int i = 0; i < 64; i++) begin
         if ((i % 16) == 0) begin
            set_gpio_in();
         end
         r = $random(seed);
         bus_cmd(pick_addr(r[13]), pick_msk(), r);
      end
      bp_max = 0;
      finish_test();

      $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // 20 cycles per command is well above the worst stall
   initial begin
      #((N_CMDS * 20 + 100) * CLK_NS);
      $display("run timed out, the DUT stopped answering commands");
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
pb_pkg.sv
spi_pkg.sv
pb_if.sv
pb_addr_decode.sv
soc_pb_spi_master.sv
soc_pb_gpio.sv
pb_resp_mux.sv
soc_pb_periph_top.sv
tb_clk_gen.sv
tb_soc_pb_periph.sv

/* Makefile */
TOP := tb_soc_pb_periph

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee run.log
	grep -q "TESTBENCH PASSED" run.log

clean:
	rm -rf obj_dir run.log
